/* Makefile */
VERILATOR ?= verilator
TOP       ?= calc_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/calc_assert.sv */
module calc_assert
    import calc_pkg::*;
(
    input logic      rst,
    input logic      clk_100hz,
    input calc_cmd_t cmd,
    input bcd_t      result_bcd,
    input logic      result_valid
);

    logic digits_ok;

    always_comb
    begin
        digits_ok = 1'b1;
        for (int d = 0; d < BCD_DIGITS; d++)
        begin
            if (result_bcd[d] > 4'd9)
                digits_ok = 1'b0;
        end
    end

    // done is a single-cycle pulse
    valid_pulse: assert property (@(posedge rst) disable iff (clk_100hz)
        result_valid |=> !result_valid)
        else $error("result_valid high two cycles running");

    bcd_digits: assert property (@(posedge rst) disable iff (clk_100hz)
        result_valid |-> digits_ok)
        else $error("result digit above nine");

    // sign step, 32 shifts, registered pulse
    conv_latency: assert property (@(posedge rst) disable iff (clk_100hz)
        cmd.conv_start |-> ##(BCD_STEPS + 2) result_valid)
        else $error("result_valid not at the fixed conversion latency");

    strobe_mix: assert property (@(posedge rst) disable iff (clk_100hz)
        !(cmd.fold_en && cmd.digit_en) && (!cmd.clear_en || cmd.digit_en))
        else $error("illegal command strobe combination");

endmodule

bind calc_top calc_assert u_calc_assert (
    .rst          (rst),
    .clk_100hz    (clk_100hz),
    .cmd          (cmd),
    .result_bcd   (result_bcd),
    .result_valid (result_valid)
);

/* sim/calc_tb.sv */
module calc_tb
    import calc_pkg::*;
();

    logic                  rst = 1'b0;
    logic                  clk_100hz;
    logic [DIGIT_KEYS-1:0] digit_keys;
    op_keys_t              op_keys;
    bcd_t                  result_bcd;
    logic                  result_neg;
    logic                  result_valid;

    string name_q[$];
    string keys_q[$];
    int    exp_q[$];
    int    watch_cycles = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    int    bad_tokens = 0;

    calc_top dut0 (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .digit_keys   (digit_keys),
        .op_keys      (op_keys),
        .result_bcd   (result_bcd),
        .result_neg   (result_neg),
        .result_valid (result_valid)
    );

    always #5 rst = ~rst;

    // strict left to right, wrapping 32-bit arithmetic
    function automatic int eval_keys(input string keys);
        int  acc;
        int  term;
        int  t;
        bit  neg;
        byte pend;
        byte c;
        acc  = 0;
        term = 0;
        neg  = 1'b0;
        pend = "+";
        for (int i = 0; i < keys.len(); i++)
        begin
            c = keys[i];
            if (c >= "0" && c <= "9")
                term = term * 10 + (int'(c) - 48);
            else if (c == "n")
                neg = 1'b1;
            else
            begin
                t = neg ? -term : term;
                case (pend)
                    "-": acc = acc - t;
                    "x": acc = acc * t;
                    // zero divisor keeps the accumulator
                    "/": acc = (t == 0) ? acc : acc / t;
                    default: acc = acc + t;
                endcase
                pend = (c == "=") ? "+" : c;
                term = 0;
                neg  = 1'b0;
            end
        end
        return acc;
    endfunction

    function automatic bcd_t to_bcd(input longint mag);
        bcd_t   b;
        longint m;
        b = '0;
        m = mag;
        for (int d = 0; d < BCD_DIGITS; d++)
        begin
            b[d] = 4'(m % 10);
            m = m / 10;
        end
        return b;
    endfunction

    // starts and ends 1 time unit after a rising edge
    task automatic press_key(input byte c);
        int hold;
        int gap;
        hold = 2 + int'($urandom % 4);
        gap  = 2 + int'($urandom % 4);
        if (c >= "0" && c <= "9")
            digit_keys[int'(c) - 48] = 1'b1;
        else
        begin
            case (c)
                "n": op_keys.neg = 1'b1;
                "+": op_keys.add = 1'b1;
                "-": op_keys.sub = 1'b1;
                "x": op_keys.mul = 1'b1;
                "/": op_keys.div = 1'b1;
                "=": op_keys.equ = 1'b1;
                default:
                begin
                    $display("unknown key token '%c' in the vector file", c);
                    bad_tokens++;
                end
            endcase
        end
        repeat (hold) @(posedge rst);
        #1;
        digit_keys = '0;
        op_keys    = '0;
        repeat (gap) @(posedge rst);
        #1;
    endtask

    task automatic run_test(input string name, input string keys, input int exp_val);
        bcd_t   exp_bcd;
        logic   exp_neg;
        longint mag;
        int     errors;
        errors  = 0;
        mag     = (exp_val < 0) ? -longint'(exp_val) : longint'(exp_val);
        exp_bcd = to_bcd(mag);
        exp_neg = (exp_val < 0);
        assert (eval_keys(keys) == exp_val)
        else
        begin
            $display("%s: listed result %0d does not follow from the keys %s", name, exp_val,
                     keys);
            errors++;
        end
        for (int i = 0; i < keys.len(); i++)
            press_key(keys[i]);
        while (!result_valid)
        begin
            @(posedge rst);
            #1;
        end
        assert (result_bcd == exp_bcd)
        else
        begin
            $display("** Error %s: digits expected %h actual %h", name, exp_bcd, result_bcd);
            errors++;
        end
        assert (result_neg == exp_neg)
        else
        begin
            $display("** Error %s: sign expected %b actual %b", name, exp_neg, result_neg);
            errors++;
        end
        if (errors == 0)
            pass_count++;
        else
            fail_count++;
        $display("%s %s", name, (errors == 0) ? "passed" : "failed");
    endtask

    initial
    begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge rst);
        $display("timeout: the tests did not finish within %0d cycles", watch_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int    fd;
        int    max_tokens;
        int    exp_val;
        string line;
        string name;
        string keys;
        digit_keys = '0;
        op_keys    = '0;
        clk_100hz  = 1'b1;
        max_tokens = 0;
        void'($urandom(36));
        fd = $fopen("sim/calc_vectors.txt", "r");
        if (fd == 0)
            $display("cannot open the vector file sim/calc_vectors.txt");
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(line, fd) == 0)
                    continue;
                if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
                    continue;
                if ($sscanf(line, "%s %s %d", name, keys, exp_val) == 3)
                begin
                    name_q.push_back(name);
                    keys_q.push_back(keys);
                    exp_q.push_back(exp_val);
                    if (keys.len() > max_tokens)
                        max_tokens = keys.len();
                end
            end
            $fclose(fd);
        end
        // ten cycles per key at most, forty per result
        watch_cycles = name_q.size() * max_tokens * 10 + 40 * name_q.size();

        repeat (5) @(posedge rst);
        #1;
        clk_100hz = 1'b0;

        foreach (name_q[i])
            run_test(name_q[i], keys_q[i], exp_q[i]);

        $display("tests %0d, passed %0d, failed %0d", name_q.size(), pass_count, fail_count);
        if (fail_count == 0 && bad_tokens == 0 && name_q.size() > 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* sim/calc_vectors.txt */
# columns: test name, key tokens pressed in order, expected signed result
# tokens: 0-9 digit keys, n sign, + - x / operators, = equals
add_multi_digit      12+345=         357
left_to_right_mul    2+3x4=          20
left_to_right_div    100/7-3=        11
sign_key_mul         n5x3=           -15
negative_result      3-10=           -7
div_trunc_negative   n7/2=           -3
div_by_zero          9/0=            9
new_calc_first       4+4=            8
new_calc_second      6x2=            12
wrap_max_plus_one    2147483647+1=   -2147483648

/* src/bin_to_bcd.sv */
module bin_to_bcd
    import calc_pkg::*;
(
    input  logic                     rst,
    input  logic                     clk_100hz,
    input  logic                     conv_start,
    input  logic signed [WORD_W-1:0] result,
    output bcd_t                     result_bcd,
    output logic                     result_neg,
    output logic                     result_valid
);

    typedef enum logic [1:0] {
        CONV_IDLE,
        CONV_LOAD,
        CONV_SHIFT
    } conv_e;

    conv_e             conv_state;
    logic [STEP_W-1:0] step;
    logic [WORD_W-1:0] mag_in;
    logic [WORD_W-1:0] mag_sr;
    logic              neg_q;
    bcd_t              bcd_sr;
    bcd_t              bcd_adj;
    logic [BCD_W-1:0]  adj_flat;
    logic [BCD_W-1:0]  bcd_next;

    // most negative value maps to 2**(WORD_W-1), still fits unsigned
    assign mag_in = result[WORD_W-1] ? -result : result;

    // add three to every digit of five or more
    always_comb
    begin
        bcd_adj = bcd_sr;
        for (int d = 0; d < BCD_DIGITS; d++)
        begin
            if (bcd_sr[d] >= 4'd5)
                bcd_adj[d] = bcd_sr[d] + 4'd3;
        end
    end

    assign adj_flat = bcd_adj;
    assign bcd_next = {adj_flat[BCD_W-2:0], mag_sr[WORD_W-1]};

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            conv_state   <= CONV_IDLE;
            step         <= '0;
            result_bcd   <= '0;
            result_neg   <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= 1'b0;
            case (conv_state)
                // accumulator settles one cycle after the start strobe
                CONV_IDLE:
                begin
                    if (conv_start)
                        conv_state <= CONV_LOAD;
                end
                CONV_LOAD:
                begin
                    step       <= '0;
                    conv_state <= CONV_SHIFT;
                end
                CONV_SHIFT:
                begin
                    step <= step + 1'b1;
                    // last shift goes straight to the outputs
                    if (step == STEP_W'(BCD_STEPS - 1))
                    begin
                        result_bcd   <= bcd_next;
                        result_neg   <= neg_q;
                        result_valid <= 1'b1;
                        conv_state   <= CONV_IDLE;
                    end
                end
                default: conv_state <= CONV_IDLE;
            endcase
        end
    end

    always_ff @(posedge rst)
    begin
        if (conv_state == CONV_LOAD)
        begin
            mag_sr <= mag_in;
            neg_q  <= result[WORD_W-1];
            bcd_sr <= '0;
        end
        else if (conv_state == CONV_SHIFT)
        begin
            mag_sr <= mag_sr << 1;
            bcd_sr <= bcd_next;
        end
    end

endmodule

/* src/calc_control.sv */
module calc_control
    import calc_pkg::*;
(
    input  logic       rst,
    input  logic       clk_100hz,
    input  key_event_t key_event,
    input  logic       result_valid,
    output calc_cmd_t  cmd
);

    typedef enum logic [2:0] {
        IDLE,
        OPERAND,
        OPERATOR,
        CONVERT,
        SHOWN
    } state_e;

    state_e    state;
    state_e    state_next;
    calc_cmd_t cmd_next;
    logic      is_digit;
    logic      is_op;
    logic      is_neg;
    logic      is_equ;
    logic      is_arith;

    assign is_digit = key_event.valid && key_event.is_digit;
    assign is_op    = key_event.valid && !key_event.is_digit;
    assign is_neg   = is_op && (key_event.word.op == OP_NEG);
    assign is_equ   = is_op && (key_event.word.op == OP_EQU);
    assign is_arith = is_op && !is_neg && !is_equ;

    always_comb
    begin
        state_next = state;
        cmd_next   = '0;

        // sign key works everywhere but during conversion
        if (is_neg && (state != CONVERT))
            cmd_next.neg_en = 1'b1;

        case (state)
            IDLE:
            begin
                if (is_digit)
                begin
                    cmd_next.digit_en = 1'b1;
                    state_next        = OPERAND;
                end
            end
            OPERAND:
            begin
                if (is_digit)
                    cmd_next.digit_en = 1'b1;
                else if (is_arith)
                begin
                    cmd_next.fold_en = 1'b1;
                    state_next       = OPERATOR;
                end
                else if (is_equ)
                begin
                    cmd_next.fold_en    = 1'b1;
                    cmd_next.conv_start = 1'b1;
                    state_next          = CONVERT;
                end
            end
            OPERATOR:
            begin
                if (is_digit)
                begin
                    cmd_next.digit_en = 1'b1;
                    state_next        = OPERAND;
                end
            end
            CONVERT:
            begin
                if (result_valid)
                    state_next = SHOWN;
            end
            SHOWN:
            begin
                // first digit after a result starts over
                if (is_digit)
                begin
                    cmd_next.clear_en = 1'b1;
                    cmd_next.digit_en = 1'b1;
                    state_next        = OPERAND;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state <= IDLE;
            cmd   <= '0;
        end
        else
        begin
            state <= state_next;
            cmd   <= cmd_next;
        end
    end

endmodule

/* src/calc_pkg.sv */
package calc_pkg;

    // datapath and keypad sizes
    localparam int WORD_W     = 32;
    localparam int DIGIT_KEYS = 10;
    localparam int BCD_DIGITS = 10;
    localparam int BCD_W      = 4 * BCD_DIGITS;
    localparam int BCD_STEPS  = WORD_W;

    // counter width for the conversion shift steps
    localparam int STEP_W = $clog2(BCD_STEPS);

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_MUL = 4'd2,
        OP_DIV = 4'd3,
        OP_NEG = 4'd4,
        OP_EQU = 4'd5
    } op_e;

    // operator key group, one level bit per key
    typedef struct packed {
        logic neg;
        logic add;
        logic sub;
        logic mul;
        logic div;
        logic equ;
    } op_keys_t;

    // key code word, read as a digit value or as an operator code
    typedef union packed {
        logic [3:0] digit;
        op_e        op;
    } key_word_u;

    // is_digit tells which view of word is valid
    typedef struct packed {
        logic      valid;
        logic      is_digit;
        key_word_u word;
    } key_event_t;

    // one-cycle datapath strobes
    typedef struct packed {
        logic digit_en;
        logic neg_en;
        logic fold_en;
        logic clear_en;
        logic conv_start;
    } calc_cmd_t;

    // most significant digit in the top nibble
    typedef logic [BCD_DIGITS-1:0][3:0] bcd_t;

endpackage

/* src/calc_top.sv */
module calc_top
    import calc_pkg::*;
(
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  logic [DIGIT_KEYS-1:0] digit_keys,
    input  op_keys_t              op_keys,
    output bcd_t                  result_bcd,
    output logic                  result_neg,
    output logic                  result_valid
);

    key_event_t               key_event;
    calc_cmd_t                cmd;
    logic signed [WORD_W-1:0] result;

    key_encoder u_key_encoder (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_keys (digit_keys),
        .op_keys    (op_keys),
        .key_event  (key_event)
    );

    calc_control u_calc_control (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .key_event    (key_event),
        .result_valid (result_valid),
        .cmd          (cmd)
    );

    // only the code word reaches the datapath
    term_accum u_term_accum (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .cmd       (cmd),
        .word      (key_event.word),
        .result    (result)
    );

    bin_to_bcd u_bin_to_bcd (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .conv_start   (cmd.conv_start),
        .result       (result),
        .result_bcd   (result_bcd),
        .result_neg   (result_neg),
        .result_valid (result_valid)
    );

endmodule

/* src/key_encoder.sv */
module key_encoder
    import calc_pkg::*;
(
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  logic [DIGIT_KEYS-1:0] digit_keys,
    input  op_keys_t              op_keys,
    output key_event_t            key_event
);

    logic [DIGIT_KEYS-1:0] digit_q;
    logic [DIGIT_KEYS-1:0] digit_prev;
    op_keys_t              op_q;
    op_keys_t              op_prev;
    logic                  digit_press;
    logic                  op_press;
    logic [3:0]            digit_code;
    op_e                   op_code;
    key_event_t            event_next;

    // sample both groups and keep the previous sample
    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            digit_q    <= '0;
            digit_prev <= '0;
            op_q       <= '0;
            op_prev    <= '0;
        end
        else
        begin
            digit_q    <= digit_keys;
            digit_prev <= digit_q;
            op_q       <= op_keys;
            op_prev    <= op_q;
        end
    end

    // a group counts as pressed only when it was all low before
    assign digit_press = (|digit_q) && !(|digit_prev);
    assign op_press    = (|op_q) && !(|op_prev);

    // lowest index wins
    always_comb
    begin
        digit_code = 4'd0;
        for (int i = DIGIT_KEYS - 1; i >= 0; i--)
        begin
            if (digit_q[i])
                digit_code = 4'(i);
        end
    end

    always_comb
    begin
        if (op_q.neg)
            op_code = OP_NEG;
        else if (op_q.add)
            op_code = OP_ADD;
        else if (op_q.sub)
            op_code = OP_SUB;
        else if (op_q.mul)
            op_code = OP_MUL;
        else if (op_q.div)
            op_code = OP_DIV;
        else
            op_code = OP_EQU;
    end

    // digit group beats the operator group
    always_comb
    begin
        event_next = '0;
        if (digit_press)
        begin
            event_next.valid      = 1'b1;
            event_next.is_digit   = 1'b1;
            event_next.word.digit = digit_code;
        end
        else if (op_press)
        begin
            event_next.valid   = 1'b1;
            event_next.word.op = op_code;
        end
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            key_event <= '0;
        else
            key_event <= event_next;
    end

endmodule

/* src/term_accum.sv */
module term_accum
    import calc_pkg::*;
(
    input  logic                     rst,
    input  logic                     clk_100hz,
    input  calc_cmd_t                cmd,
    input  key_word_u                word,
    output logic signed [WORD_W-1:0] result
);

    logic [WORD_W-1:0]        term_mag;
    logic                     term_neg;
    op_e                      pend_op;
    logic signed [WORD_W-1:0] acc;
    logic signed [WORD_W-1:0] term_s;
    logic signed [WORD_W-1:0] fold_val;
    op_e                      op_next;
    key_word_u                word_q;

    assign term_s = term_neg ? -$signed(term_mag) : $signed(term_mag);
    assign result = acc;

    // strict left to right, no precedence
    always_comb
    begin
        case (pend_op)
            OP_SUB:  fold_val = acc - term_s;
            OP_MUL:  fold_val = acc * term_s;
            // divide by zero keeps the old value
            OP_DIV:  fold_val = (term_s == '0) ? acc : acc / term_s;
            default: fold_val = acc + term_s;
        endcase
    end

    // equals leaves an add pending
    always_comb
    begin
        case (word_q.op)
            OP_ADD, OP_SUB, OP_MUL, OP_DIV: op_next = word_q.op;
            default:                        op_next = OP_ADD;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            term_mag <= '0;
            term_neg <= 1'b0;
            pend_op  <= OP_ADD;
            acc      <= '0;
            word_q   <= '0;
        end
        else
        begin
            // key word delayed to line up with its command
            word_q <= word;
            if (cmd.clear_en)
            begin
                acc     <= '0;
                pend_op <= OP_ADD;
            end
            if (cmd.fold_en)
            begin
                acc      <= fold_val;
                pend_op  <= op_next;
                term_mag <= '0;
                term_neg <= 1'b0;
            end
            // wraps modulo 2**WORD_W
            if (cmd.digit_en)
                term_mag <= term_mag * WORD_W'(10) + WORD_W'(word_q.digit);
            if (cmd.neg_en)
                term_neg <= 1'b1;
        end
    end

endmodule

/* verilog.f */
src/calc_pkg.sv
src/key_encoder.sv
src/calc_control.sv
src/term_accum.sv
src/bin_to_bcd.sv
src/calc_top.sv
sim/calc_assert.sv
sim/calc_tb.sv
